// ==== project.f ====
rtl/rrag_mem_pkg.sv
rtl/rrag_agen.sv
rtl/stage_latch.sv
rtl/pipe_ctrl.sv
rtl/mem_stage.sv
rtl/rrag_mem_top.sv
tests/tb_rrag_mem.sv

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  rrag_mem_pkg::rrag_mem_t rec,
    output rrag_mem_pkg::mem_wb_t   wb
);

    logic [7:0]                      mem [rrag_mem_pkg::MEM_BYTES];
    logic [3:0]                      nbytes;
    logic [3:0]                      first_cnt;
    logic [rrag_mem_pkg::MEM_AW-1:0] start_idx;
    logic [rrag_mem_pkg::MEM_AW-1:0] next_word_idx;
    logic [rrag_mem_pkg::MEM_AW-1:0] lane_idx [rrag_mem_pkg::WORD_BYTES];
    logic [rrag_mem_pkg::DATA_W-1:0] load_data;
    logic                            fault;
    logic                            do_store;

    assign nbytes    = rrag_mem_pkg::size_bytes(rec.opsize);
    assign start_idx = rec.mem_addr[rrag_mem_pkg::MEM_AW-1:0];

    // number of bytes that still fit in the start word.
    assign first_cnt = 4'(rrag_mem_pkg::WORD_BYTES) -
                       {1'b0, rec.mem_addr[rrag_mem_pkg::WORD_LSB-1:0]};

    assign next_word_idx = {rec.mem_addr_end[rrag_mem_pkg::MEM_AW-1:rrag_mem_pkg::WORD_LSB],
                            {rrag_mem_pkg::WORD_LSB{1'b0}}};

    // Byte lane k maps to a memory index, and lanes past the start word are taken
    // from the word that holds the end address. Indices wrap modulo the memory size.
    always_comb begin
        for (int k = 0; k < rrag_mem_pkg::WORD_BYTES; k++) begin
            if (rec.mem_end_is_valid && k[3:0] >= first_cnt) begin
                lane_idx[k] = next_word_idx + k[rrag_mem_pkg::MEM_AW-1:0] -
                              {{(rrag_mem_pkg::MEM_AW-4){1'b0}}, first_cnt};
            end else begin
                lane_idx[k] = start_idx + k[rrag_mem_pkg::MEM_AW-1:0];
            end
        end
    end

    always_comb begin
        load_data = '0;  // bytes above the access size stay zero.
        for (int k = 0; k < rrag_mem_pkg::WORD_BYTES; k++) begin
            if (k[3:0] < nbytes) begin
                load_data[8*k +: 8] = mem[lane_idx[k]];
            end
        end
    end

    assign fault    = rec.valid & rec.seg_fault;
    assign do_store = rec.valid & rec.is_store & ~rec.seg_fault;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rrag_mem_pkg::MEM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (wr_en && do_store) begin
            for (int k = 0; k < rrag_mem_pkg::WORD_BYTES; k++) begin
                if (k[3:0] < nbytes) begin
                    mem[lane_idx[k]] <= rec.store_data[8*k +: 8];
                end
            end
        end
    end

    always_comb begin
        wb.valid    = rec.valid;
        wb.dest     = rec.dest;
        wb.is_store = rec.is_store;
        wb.fault    = fault;
        wb.eip      = rec.eip;
        // only a good load returns data.
        wb.data     = (rec.valid && !rec.is_store && !rec.seg_fault) ? load_data : '0;
    end

endmodule

// ==== rtl/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic hold,
    input  logic flush,
    input  logic wb_fault,
    output logic ld_pipe,
    output logic clr_rrag,
    output logic clr_wb,
    output logic fault_pending
);

    assign ld_pipe = ~hold;
    assign clr_wb  = flush;

    // while a fault waits for its flush, younger ops are dropped at the first latch.
    assign clr_rrag = flush | (fault_pending & ~flush);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fault_pending <= 1'b0;
        end else if (flush) begin
            fault_pending <= 1'b0;
        end else if (wb_fault && ld_pipe) begin
            fault_pending <= 1'b1; // the faulting record lands in result on this edge.
        end
    end

endmodule

// ==== rtl/rrag_agen.sv ====
`timescale 1ns/1ps

module rrag_agen (
    input  logic                            in_valid,
    input  rrag_mem_pkg::uop_t              uop,
    input  rrag_mem_pkg::agen_req_t         agen,
    input  logic [rrag_mem_pkg::DATA_W-1:0] store_data,
    output rrag_mem_pkg::rrag_mem_t         rec
);

    logic [3:0]                      nbytes;
    logic [rrag_mem_pkg::ADDR_W-1:0] len_m1;
    logic [rrag_mem_pkg::ADDR_W-1:0] scaled_index;
    logic [rrag_mem_pkg::ADDR_W-1:0] offset;
    logic [rrag_mem_pkg::ADDR_W-1:0] last_off;
    logic [rrag_mem_pkg::ADDR_W-1:0] lin_addr;
    logic [rrag_mem_pkg::ADDR_W-1:0] lin_end;
    logic [rrag_mem_pkg::ADDR_W-1:0] lim_ext;
    logic                            crosses;

    assign nbytes = rrag_mem_pkg::size_bytes(uop.opsize);
    assign len_m1 = {{(rrag_mem_pkg::ADDR_W-4){1'b0}}, nbytes - 4'd1};

    // effective offset within the segment, all sums wrap at 32 bits.
    assign scaled_index = agen.index << agen.scale;
    assign offset       = agen.base + scaled_index + agen.disp;
    assign last_off     = offset + len_m1;   // offset of the last byte touched.

    assign lin_addr = agen.seg_base + offset;
    assign lin_end  = lin_addr + len_m1;

    assign lim_ext = {{(rrag_mem_pkg::ADDR_W-rrag_mem_pkg::LIM_W){1'b0}}, agen.seg_lim};

    // The end byte sits in another word when the word numbers differ.
    assign crosses = lin_addr[rrag_mem_pkg::ADDR_W-1:rrag_mem_pkg::WORD_LSB] !=
                     lin_end[rrag_mem_pkg::ADDR_W-1:rrag_mem_pkg::WORD_LSB];

    always_comb begin
        rec.valid            = in_valid;
        rec.opsize           = uop.opsize;
        rec.mem_addr         = lin_addr;
        rec.mem_addr_end     = lin_end;
        rec.mem_end_is_valid = crosses;
        rec.seg_fault        = last_off > lim_ext; // limit is inclusive.
        rec.is_store         = uop.is_store;
        rec.dest             = uop.dest;
        rec.store_data       = store_data;
        rec.eip              = uop.eip;
    end

endmodule

// ==== rtl/rrag_mem_pkg.sv ====
package rrag_mem_pkg;

    localparam int MEM_BYTES  = 256;
    localparam int MEM_AW     = $clog2(MEM_BYTES);
    localparam int WORD_BYTES = 8;
    localparam int WORD_LSB   = $clog2(WORD_BYTES);
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int DEST_W     = 13;
    localparam int LIM_W      = 20;

    // access size code, the byte count is a power of two.
    typedef logic [1:0] size_t;

    localparam size_t SZ_BYTE  = 2'd0;
    localparam size_t SZ_WORD  = 2'd1;
    localparam size_t SZ_DWORD = 2'd2;
    localparam size_t SZ_QWORD = 2'd3;

    function automatic logic [3:0] size_bytes(input size_t sz);
        logic [3:0] n;
        n = 4'd1;
        case (sz)
            SZ_BYTE:  n = 4'd1;
            SZ_WORD:  n = 4'd2;
            SZ_DWORD: n = 4'd4;
            SZ_QWORD: n = 4'd8;
        endcase
        return n;
    endfunction

    typedef struct packed {
        logic [DEST_W-1:0] dest;
        size_t             opsize;
        logic              is_store;
        logic [ADDR_W-1:0] eip;
    } uop_t;

    typedef struct packed {
        logic [ADDR_W-1:0] seg_base;
        logic [LIM_W-1:0]  seg_lim;
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] index;
        logic [1:0]        scale;
        logic [ADDR_W-1:0] disp;
    } agen_req_t;

    typedef struct packed {
        logic              valid;
        size_t             opsize;
        logic [ADDR_W-1:0] mem_addr;
        logic [ADDR_W-1:0] mem_addr_end;     // linear address of the last byte.
        logic              mem_end_is_valid; // the access reaches into the next word.
        logic              seg_fault;
        logic              is_store;
        logic [DEST_W-1:0] dest;
        logic [DATA_W-1:0] store_data;
        logic [ADDR_W-1:0] eip;
    } rrag_mem_t;

    typedef struct packed {
        logic              valid;
        logic [DEST_W-1:0] dest;
        logic [DATA_W-1:0] data;
        logic              is_store;
        logic              fault;
        logic [ADDR_W-1:0] eip;
    } mem_wb_t;

endpackage

// ==== rtl/rrag_mem_top.sv ====
`timescale 1ns/1ps

module rrag_mem_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  rrag_mem_pkg::uop_t              uop,
    input  rrag_mem_pkg::agen_req_t         agen,
    input  logic [rrag_mem_pkg::DATA_W-1:0] store_data,
    input  logic                            hold,
    input  logic                            flush,
    output rrag_mem_pkg::mem_wb_t           result,
    output logic                            fault_pending
);

    rrag_mem_pkg::rrag_mem_t agen_rec;
    rrag_mem_pkg::rrag_mem_t mem_rec;
    rrag_mem_pkg::mem_wb_t   wb_rec;
    logic                    ld_pipe;
    logic                    clr_rrag;
    logic                    clr_wb;

    rrag_agen u_agen (
        .in_valid   (in_valid),
        .uop        (uop),
        .agen       (agen),
        .store_data (store_data),
        .rec        (agen_rec)
    );

    // RrAg to MEM latch.
    stage_latch #(
        .payload_t (rrag_mem_pkg::rrag_mem_t)
    ) u_rrag_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .ld    (ld_pipe),
        .clr   (clr_rrag),
        .din   (agen_rec),
        .dout  (mem_rec)
    );

    mem_stage u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (ld_pipe),  // a held store is written once, on release.
        .rec   (mem_rec),
        .wb    (wb_rec)
    );

    // MEM to writeback latch.
    stage_latch #(
        .payload_t (rrag_mem_pkg::mem_wb_t)
    ) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .ld    (ld_pipe),
        .clr   (clr_wb),
        .din   (wb_rec),
        .dout  (result)
    );

    pipe_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .hold          (hold),
        .flush         (flush),
        .wb_fault      (wb_rec.valid & wb_rec.fault),
        .ld_pipe       (ld_pipe),
        .clr_rrag      (clr_rrag),
        .clr_wb        (clr_wb),
        .fault_pending (fault_pending)
    );

endmodule

// ==== rtl/stage_latch.sv ====
`timescale 1ns/1ps

module stage_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ld,
    input  logic     clr,
    input  payload_t din,
    output payload_t dout
);

    // one register for the whole record, so every field moves together.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (clr) begin
            dout <= '0; // clear takes priority over load.
        end else if (ld) begin
            dout <= din;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_rrag_mem -o tb_rrag_mem
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_rrag_mem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tests/tb_rrag_mem.sv ====
`timescale 1ns/1ps

module tb_rrag_mem;

    localparam int RESULT_TIMEOUT = 100;
    localparam int LATENCY        = 2;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    in_valid;
    rrag_mem_pkg::uop_t      uop;
    rrag_mem_pkg::agen_req_t agen;
    logic [63:0]             store_data;
    logic                    hold;
    logic                    flush;
    rrag_mem_pkg::mem_wb_t   result;
    logic                    fault_pending;

    logic [7:0]            mem_m [256];  // reference copy of the data memory.
    logic [31:0]           lcg_state = 32'd12;
    int                    cyc = 0;
    logic                  ld_seen = 1'b0;
    rrag_mem_pkg::mem_wb_t res_q [$];
    int                    res_cyc_q [$];
    rrag_mem_pkg::mem_wb_t exp_q [$];
    int                    exp_cyc_q [$];  // issue edge, or -1 when latency is not fixed.
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    int                    err_base = 0;

    rrag_mem_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .uop           (uop),
        .agen          (agen),
        .store_data    (store_data),
        .hold          (hold),
        .flush         (flush),
        .result        (result),
        .fault_pending (fault_pending)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc     <= cyc + 1;
        ld_seen <= ~hold;  // whether result was loaded on this edge.
    end

    // a record is collected once, on the edge that loaded it into result.
    always @(negedge clk) begin
        if (rst_n && ld_seen && result.valid) begin
            res_q.push_back(result);
            res_cyc_q.push_back(cyc);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic rrag_mem_pkg::uop_t make_uop(input logic st, input rrag_mem_pkg::size_t sz);
        rrag_mem_pkg::uop_t u;
        logic [31:0]        r;
        r          = lcg_next();
        u.dest     = r[28:16];
        u.opsize   = sz;
        u.is_store = st;
        u.eip      = lcg_next();
        return u;
    endfunction

    function automatic rrag_mem_pkg::agen_req_t flat_addr(input logic [31:0] lin,
                                                          input logic [19:0] lim);
        rrag_mem_pkg::agen_req_t a;
        a          = '0;
        a.seg_base = lin;
        a.seg_lim  = lim;
        return a;
    endfunction

    // applies one op to the reference memory and builds the record it should produce.
    task automatic model_op(input rrag_mem_pkg::uop_t u, input rrag_mem_pkg::agen_req_t a,
                            input logic [63:0] d, output rrag_mem_pkg::mem_wb_t e);
        logic [31:0] off;
        logic [31:0] lin;
        logic [31:0] nb;
        logic [7:0]  idx;
        nb         = 32'd1 << u.opsize;
        off        = a.base + (a.index << a.scale) + a.disp;
        lin        = a.seg_base + off;
        e          = '0;
        e.valid    = 1'b1;
        e.dest     = u.dest;
        e.is_store = u.is_store;
        e.eip      = u.eip;
        e.fault    = (off + nb - 32'd1) > {12'd0, a.seg_lim};
        if (!e.fault) begin
            for (int i = 0; i < int'(nb); i++) begin
                idx = lin[7:0] + 8'(i);  // byte index wraps at the memory size.
                if (u.is_store) begin
                    mem_m[idx] = d[8*i +: 8];
                end else begin
                    e.data[8*i +: 8] = mem_m[idx];
                end
            end
        end
    endtask

    task automatic drive(input logic v, input rrag_mem_pkg::uop_t u,
                         input rrag_mem_pkg::agen_req_t a, input logic [63:0] d,
                         input logic h, input logic f, input bit track, input bit timed);
        rrag_mem_pkg::mem_wb_t e;
        @(posedge clk);
        in_valid   <= v;
        uop        <= u;
        agen       <= a;
        store_data <= d;
        hold       <= h;
        flush      <= f;
        if (track) begin
            model_op(u, a, d, e);
            exp_q.push_back(e);
            exp_cyc_q.push_back(timed ? cyc + 1 : -1);
        end
    endtask

    task automatic issue(input rrag_mem_pkg::uop_t u, input rrag_mem_pkg::agen_req_t a,
                         input logic [63:0] d);
        drive(1'b1, u, a, d, 1'b0, 1'b0, 1'b1, 1'b1);
    endtask

    task automatic idle(input logic h, input logic f);
        drive(1'b0, '0, '0, 64'd0, h, f, 1'b0, 1'b0);
    endtask

    task automatic check_wb(input string what, input rrag_mem_pkg::mem_wb_t got,
                            input rrag_mem_pkg::mem_wb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic collect_results(input string what);
        int                    waited;
        int                    n_exp;
        int                    gc;
        int                    ec;
        rrag_mem_pkg::mem_wb_t got;
        rrag_mem_pkg::mem_wb_t exp;
        waited = 0;
        n_exp  = exp_q.size();
        while (res_q.size() < n_exp && waited < RESULT_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (res_q.size() < n_exp) begin
            errors++;
            $display("%s: timed out, only %0d of %0d results arrived", what, res_q.size(), n_exp);
        end
        repeat (LATENCY + 2) @(posedge clk);  // anything still in flight has landed by now.
        check_int({what, " result count"}, res_q.size(), n_exp);
        while (res_q.size() > 0 && exp_q.size() > 0) begin
            got = res_q.pop_front();
            gc  = res_cyc_q.pop_front();
            exp = exp_q.pop_front();
            ec  = exp_cyc_q.pop_front();
            check_wb({what, " result"}, got, exp);
            if (ec >= 0) begin
                check_int({what, " latency"}, gc - ec, LATENCY);
            end
        end
        res_q.delete();
        res_cyc_q.delete();
        exp_q.delete();
        exp_cyc_q.delete();
    endtask

    task automatic report_test(input string what);
        tests++;
        $display("test %s finished with %0d errors", what, errors - err_base);
        err_base = errors;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("result.valid after reset", result.valid, 1'b0);
        check_bit("fault_pending after reset", fault_pending, 1'b0);
        for (int i = 0; i < 4; i++) begin
            issue(make_uop(1'b0, 2'd3), flat_addr(lcg_next(), 20'hFFFFF), 64'd0);
        end
        idle(1'b0, 1'b0);
        collect_results("reset");
        report_test("reset");
    endtask

    task automatic test_aligned();
        logic [31:0] lin;
        for (int s = 0; s < 4; s++) begin
            lin = 32'h20 + 32'(s) * 32'h10;
            issue(make_uop(1'b1, 2'(s)), flat_addr(lin, 20'hFFFFF), {lcg_next(), lcg_next()});
            issue(make_uop(1'b0, 2'(s)), flat_addr(lin, 20'hFFFFF), 64'd0);  // store to load.
        end
        issue(make_uop(1'b0, 2'd3), flat_addr(32'h20, 20'hFFFFF), 64'd0);
        idle(1'b0, 1'b0);
        collect_results("aligned");
        report_test("aligned");
    endtask

    task automatic test_unaligned();
        rrag_mem_pkg::agen_req_t a;
        logic [31:0]             r;
        for (int i = 0; i < 24; i++) begin
            r          = lcg_next();
            a.seg_base = lcg_next();
            a.seg_lim  = 20'hFFFFF;
            a.base     = {24'd0, r[7:0]};
            a.index    = {26'd0, r[13:8]};
            a.scale    = r[15:14];
            a.disp     = {24'd0, r[23:16]};
            if (i % 4 == 0) begin
                // start in the top word so wider accesses wrap past byte 255.
                a.seg_base = {a.seg_base[31:8], 5'h1F, r[26:24]};
                a.base     = '0;
                a.index    = '0;
                a.disp     = '0;
            end
            issue(make_uop(1'b1, r[29:28]), a, {lcg_next(), lcg_next()});
            issue(make_uop(1'b0, r[31:30]), a, 64'd0);
        end
        idle(1'b0, 1'b0);
        collect_results("unaligned");
        report_test("unaligned");
    endtask

    task automatic test_fault();
        rrag_mem_pkg::agen_req_t a;
        logic [63:0]             d;
        d = {lcg_next(), lcg_next()};
        issue(make_uop(1'b1, 2'd3), flat_addr(32'h40, 20'hFFFFF), d);
        a      = flat_addr(32'h0, 20'h3F);
        a.base = 32'h40;  // offset lies past the limit.
        issue(make_uop(1'b1, 2'd3), a, ~d);
        idle(1'b0, 1'b0);
        collect_results("fault");
        @(negedge clk);
        check_bit("fault_pending after fault", fault_pending, 1'b1);
        for (int i = 0; i < 3; i++) begin
            drive(1'b1, make_uop(1'b0, 2'd3), flat_addr(32'h40, 20'hFFFFF), 64'd0,
                  1'b0, 1'b0, 1'b0, 1'b0);
        end
        idle(1'b0, 1'b0);
        collect_results("fault younger ops");
        check_bit("fault_pending before flush", fault_pending, 1'b1);
        idle(1'b0, 1'b1);
        idle(1'b0, 1'b0);
        @(negedge clk);
        check_bit("fault_pending after flush", fault_pending, 1'b0);
        issue(make_uop(1'b0, 2'd3), flat_addr(32'h40, 20'hFFFFF), 64'd0);
        idle(1'b0, 1'b0);
        collect_results("fault memory");
        report_test("fault");
    endtask

    task automatic test_hold();
        rrag_mem_pkg::mem_wb_t snap;
        issue(make_uop(1'b1, 2'd3), flat_addr(32'h80, 20'hFFFFF), {lcg_next(), lcg_next()});
        drive(1'b1, make_uop(1'b1, 2'd2), flat_addr(32'h8A, 20'hFFFFF), {lcg_next(), lcg_next()},
              1'b0, 1'b0, 1'b1, 1'b0);
        drive(1'b1, make_uop(1'b1, 2'd3), flat_addr(32'h90, 20'hFFFFF), {lcg_next(), lcg_next()},
              1'b1, 1'b0, 1'b0, 1'b0);
        snap = exp_q[0];  // the first store sits in result for the whole hold.
        for (int i = 0; i < 4; i++) begin
            drive(1'b1, make_uop(1'b1, 2'd3), flat_addr(32'h90, 20'hFFFFF),
                  {lcg_next(), lcg_next()}, 1'b1, 1'b0, 1'b0, 1'b0);
            @(negedge clk);
            check_wb("result under hold", result, snap);
        end
        idle(1'b0, 1'b0);
        collect_results("hold");
        issue(make_uop(1'b0, 2'd3), flat_addr(32'h88, 20'hFFFFF), 64'd0);
        issue(make_uop(1'b0, 2'd3), flat_addr(32'h90, 20'hFFFFF), 64'd0);
        idle(1'b0, 1'b0);
        collect_results("hold memory");
        report_test("hold");
    endtask

    task automatic test_flush();
        drive(1'b1, make_uop(1'b0, 2'd3), flat_addr(32'hA0, 20'hFFFFF), 64'd0,
              1'b0, 1'b0, 1'b0, 1'b0);
        drive(1'b1, make_uop(1'b1, 2'd3), flat_addr(32'hA0, 20'hFFFFF), {lcg_next(), lcg_next()},
              1'b0, 1'b1, 1'b0, 1'b0);
        idle(1'b0, 1'b0);
        collect_results("flush");
        check_bit("fault_pending after flush", fault_pending, 1'b0);
        issue(make_uop(1'b0, 2'd3), flat_addr(32'hA0, 20'hFFFFF), 64'd0);
        idle(1'b0, 1'b0);
        collect_results("flush memory");
        report_test("flush");
    endtask

    initial begin
        rst_n      <= 1'b0;
        in_valid   <= 1'b0;
        uop        <= '0;
        agen       <= '0;
        store_data <= '0;
        hold       <= 1'b0;
        flush      <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem_m[i] = 8'h00;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_aligned();
        test_unaligned();
        test_fault();
        test_hold();
        test_flush();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
